//--- adc_frontend.sv
//////////////////////////////////////////////////////////////////////
// ADC capture, negative-slope to two's complement, loopback select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "dac_path_params.svh"

module adc_frontend (
  input  logic                  adc_clk,
  input  logic                  adc_rstn,
  input  logic                  sample_stb_i,    // New ADC word present
  input  logic                  digital_loop_i,  // Static config level
  input  logic [`ADC_RAW_W-1:0] adc_raw_a_i,
  input  logic [`ADC_RAW_W-1:0] adc_raw_b_i,
  input  dac_path_pkg::sample_t mix_a_i,         // Registered mixer sample
  input  dac_path_pkg::sample_t mix_b_i,
  output dac_path_pkg::sample_t adc_a_o,
  output dac_path_pkg::sample_t adc_b_o,
  output logic                  adc_stb_o
);

  import dac_path_pkg::*;

  logic [`SMP_W-1:0] raw_a_q;  // Top 14 bits of ADC word
  logic [`SMP_W-1:0] raw_b_q;
  sample_t           conv_a;
  sample_t           conv_b;

  // Strobe follows captured word by one cycle
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      adc_stb_o <= 1'b0;
    end else begin
      adc_stb_o <= sample_stb_i;
    end
  end

  // Drop two LSBs, hold between strobes
  always_ff @(posedge adc_clk) begin
    if (sample_stb_i) begin
      raw_a_q <= adc_raw_a_i[`ADC_RAW_W-1 -: `SMP_W];
      raw_b_q <= adc_raw_b_i[`ADC_RAW_W-1 -: `SMP_W];
    end
  end

  // Negative slope code: keep sign, flip magnitude bits
  assign conv_a = {raw_a_q[`SMP_W-1], ~raw_a_q[`SMP_W-2:0]};
  assign conv_b = {raw_b_q[`SMP_W-1], ~raw_b_q[`SMP_W-2:0]};

  // Loopback swaps in the DAC side samples
  assign adc_a_o = digital_loop_i ? mix_a_i : conv_a;
  assign adc_b_o = digital_loop_i ? mix_b_i : conv_b;

endmodule : adc_frontend

//--- avg_ctrl_fsm.sv
//////////////////////////////////////////////////////////////////////
// Averager fill tracking FSM, DAC output enable
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "dac_path_params.svh"

module avg_ctrl_fsm (
  input  logic adc_clk,
  input  logic adc_rstn,
  input  logic step_i,    // Mixed sample strobe
  input  logic wrap_i,    // Step lands on last ring slot
  output logic out_en_o   // Window full of real samples
);

  import dac_path_pkg::*;

  avg_state_e state_q;
  avg_state_e state_nxt;

  // Next state
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      AVG_IDLE: begin
        if (step_i) begin
          state_nxt = AVG_FILL;  // First sample in
        end
      end
      AVG_FILL: begin
        if (step_i && wrap_i) begin
          state_nxt = AVG_RUN;   // 64th sample in
        end
      end
      AVG_RUN: begin
        state_nxt = AVG_RUN;     // Stays until reset
      end
      default: begin
        state_nxt = AVG_IDLE;
      end
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      state_q <= AVG_IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

  // Output quiet through fill, first enabled step is sample 65
  assign out_en_o = (state_q == AVG_RUN);

endmodule : avg_ctrl_fsm

//--- avg_window_counter.sv
//////////////////////////////////////////////////////////////////////
// Ring write index over the averaging window, last-slot flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "dac_path_params.svh"

module avg_window_counter (
  input  logic                  adc_clk,
  input  logic                  adc_rstn,
  input  logic                  step_i,   // One mixed sample accepted
  output logic [`AVG_IDX_W-1:0] idx_o,    // Slot written on next step
  output logic                  wrap_o    // Index sits on last slot
);

  logic [`AVG_IDX_W-1:0] idx_q;

  ////////////////////////////////////////////////////////////////////
  // Index register
  ////////////////////////////////////////////////////////////////////

  // Window is a power of two so natural rollover gives 63 -> 0
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      idx_q <= '0;
    end else if (step_i) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////

  assign idx_o  = idx_q;
  assign wrap_o = (idx_q == {`AVG_IDX_W{1'b1}});  // Slot 63

endmodule : avg_window_counter

//--- dac_mixer.sv
//////////////////////////////////////////////////////////////////////
// Generator plus controller sum per channel with 14-bit saturation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "dac_path_params.svh"

module dac_mixer (
  input  logic                  adc_clk,
  input  logic                  adc_rstn,
  input  logic                  sample_stb_i,
  input  dac_path_pkg::sample_t asg_a_i,    // Generator samples
  input  dac_path_pkg::sample_t asg_b_i,
  input  dac_path_pkg::sample_t pid_a_i,    // Controller samples
  input  dac_path_pkg::sample_t pid_b_i,
  output dac_path_pkg::sample_t mix_a_o,
  output dac_path_pkg::sample_t mix_b_o,
  output logic                  mix_stb_o
);

  import dac_path_pkg::*;

  // One extra bit catches overflow, top two bits disagree on overflow
  function automatic sample_t sat_add(input sample_t x, input sample_t y);
    logic signed [`SMP_W:0] s;
    s = x + y;
    if (s[`SMP_W] ^ s[`SMP_W-1]) begin
      sat_add = {s[`SMP_W], {(`SMP_W-1){~s[`SMP_W]}}};  // Clamp to rail
    end else begin
      sat_add = s[`SMP_W-1:0];
    end
  endfunction

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      mix_stb_o <= 1'b0;
    end else begin
      mix_stb_o <= sample_stb_i;  // Sums valid one cycle on
    end
  end

  // Sample payload, updated only on strobe
  always_ff @(posedge adc_clk) begin
    if (sample_stb_i) begin
      mix_a_o <= sat_add(asg_a_i, pid_a_i);
      mix_b_o <= sat_add(asg_b_i, pid_b_i);
    end
  end

endmodule : dac_mixer

//--- dac_path_params.svh
//////////////////////////////////////////////////////////////////////
// Converter widths, averaging window length and ring index width
//////////////////////////////////////////////////////////////////////

`ifndef DAC_PATH_PARAMS_SVH
`define DAC_PATH_PARAMS_SVH

// Raw ADC word, two LSBs unused on 14-bit parts
`define ADC_RAW_W 16

// Sample width on both converter sides
`define SMP_W 14

// Moving average window, must stay a power of two
`define AVG_LEN 64

// Ring index width, log2 of window
`define AVG_IDX_W 6

// Running sum carries window growth on top of sample width
`define AVG_SUM_W (`SMP_W + `AVG_IDX_W)

`endif

//--- dac_path_pkg.sv
//////////////////////////////////////////////////////////////////////
// Sample, running sum and averager state types
//////////////////////////////////////////////////////////////////////

`include "dac_path_params.svh"

package dac_path_pkg;

  // One converter sample, two's complement
  typedef logic signed [`SMP_W-1:0] sample_t;

  // Sum over the full window
  typedef logic signed [`AVG_SUM_W-1:0] avg_sum_t;

  // Averager fill tracking
  typedef enum logic [1:0] {
    AVG_IDLE = 2'd0,  // Nothing seen since reset
    AVG_FILL = 2'd1,  // Window partly filled
    AVG_RUN  = 2'd2   // Window full, output valid
  } avg_state_e;

endpackage : dac_path_pkg

//--- dac_path_top.f
+incdir+.
dac_path_pkg.sv
adc_frontend.sv
dac_mixer.sv
avg_window_counter.sv
avg_ctrl_fsm.sv
moving_avg.sv
dac_path_top.sv
tb_clk_gen.sv
tb_dac_path_top.sv

//--- dac_path_top.sv
//////////////////////////////////////////////////////////////////////
// Mixed-signal data path top, ADC front end through DAC averaging
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "dac_path_params.svh"

module dac_path_top (
  input  logic                  adc_clk,
  input  logic                  adc_rstn,
  input  logic                  sample_stb_i,    // One sample on all inputs
  input  logic                  digital_loop_i,
  input  logic [`ADC_RAW_W-1:0] adc_raw_a_i,
  input  logic [`ADC_RAW_W-1:0] adc_raw_b_i,
  input  dac_path_pkg::sample_t asg_a_i,
  input  dac_path_pkg::sample_t asg_b_i,
  input  dac_path_pkg::sample_t pid_a_i,
  input  dac_path_pkg::sample_t pid_b_i,
  output dac_path_pkg::sample_t adc_a_o,
  output dac_path_pkg::sample_t adc_b_o,
  output logic                  adc_stb_o,
  output logic [`SMP_W-1:0]     dac_a_o,
  output logic [`SMP_W-1:0]     dac_b_o,
  output logic                  dac_stb_o
);

  import dac_path_pkg::*;

  sample_t               mix_a;    // Saturated DAC samples
  sample_t               mix_b;
  logic                  mix_stb;
  logic [`AVG_IDX_W-1:0] avg_idx;  // Ring write slot
  logic                  avg_wrap;
  logic                  out_en;

  ////////////////////////////////////////////////////////////////////
  // ADC side
  ////////////////////////////////////////////////////////////////////

  adc_frontend i_frontend (
    .adc_clk        (adc_clk       ),
    .adc_rstn       (adc_rstn      ),
    .sample_stb_i   (sample_stb_i  ),
    .digital_loop_i (digital_loop_i),
    .adc_raw_a_i    (adc_raw_a_i   ),
    .adc_raw_b_i    (adc_raw_b_i   ),
    .mix_a_i        (mix_a         ),  // Loopback source
    .mix_b_i        (mix_b         ),
    .adc_a_o        (adc_a_o       ),
    .adc_b_o        (adc_b_o       ),
    .adc_stb_o      (adc_stb_o     )
  );

  ////////////////////////////////////////////////////////////////////
  // DAC side
  ////////////////////////////////////////////////////////////////////

  dac_mixer i_mixer (
    .adc_clk      (adc_clk     ),
    .adc_rstn     (adc_rstn    ),
    .sample_stb_i (sample_stb_i),
    .asg_a_i      (asg_a_i     ),
    .asg_b_i      (asg_b_i     ),
    .pid_a_i      (pid_a_i     ),
    .pid_b_i      (pid_b_i     ),
    .mix_a_o      (mix_a       ),
    .mix_b_o      (mix_b       ),
    .mix_stb_o    (mix_stb     )
  );

  avg_window_counter i_win_cnt (
    .adc_clk  (adc_clk ),
    .adc_rstn (adc_rstn),
    .step_i   (mix_stb ),
    .idx_o    (avg_idx ),
    .wrap_o   (avg_wrap)
  );

  avg_ctrl_fsm i_avg_ctrl (
    .adc_clk  (adc_clk ),
    .adc_rstn (adc_rstn),
    .step_i   (mix_stb ),
    .wrap_i   (avg_wrap),
    .out_en_o (out_en  )
  );

  moving_avg i_avg (
    .adc_clk   (adc_clk  ),
    .adc_rstn  (adc_rstn ),
    .step_i    (mix_stb  ),
    .out_en_i  (out_en   ),
    .idx_i     (avg_idx  ),
    .mix_a_i   (mix_a    ),
    .mix_b_i   (mix_b    ),
    .dac_a_o   (dac_a_o  ),
    .dac_b_o   (dac_b_o  ),
    .dac_stb_o (dac_stb_o)
  );

endmodule : dac_path_top

//--- moving_avg.sv
//////////////////////////////////////////////////////////////////////
// 64-sample moving average per channel and DAC output coding
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "dac_path_params.svh"

module moving_avg (
  input  logic                  adc_clk,
  input  logic                  adc_rstn,
  input  logic                  step_i,    // New mixed sample
  input  logic                  out_en_i,  // Window full
  input  logic [`AVG_IDX_W-1:0] idx_i,     // Ring slot to replace
  input  dac_path_pkg::sample_t mix_a_i,
  input  dac_path_pkg::sample_t mix_b_i,
  output logic [`SMP_W-1:0]     dac_a_o,   // Negative slope offset code
  output logic [`SMP_W-1:0]     dac_b_o,
  output logic                  dac_stb_o
);

  import dac_path_pkg::*;

  sample_t           mix_in [2];  // Channel select for the loop below
  logic [`SMP_W-1:0] dac_q  [2];

  assign mix_in[0] = mix_a_i;
  assign mix_in[1] = mix_b_i;

  ////////////////////////////////////////////////////////////////////
  // Per channel history and running sum
  ////////////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < 2; ch++) begin : g_chan
    sample_t  hist_q [`AVG_LEN];  // Past samples, ring ordered
    avg_sum_t sum_q;
    avg_sum_t sum_nxt;

    // Add newest, drop the one leaving the window
    assign sum_nxt = sum_q + avg_sum_t'(mix_in[ch]) - avg_sum_t'(hist_q[idx_i]);

    always_ff @(posedge adc_clk) begin
      if (!adc_rstn) begin
        sum_q <= '0;
        for (int i = 0; i < `AVG_LEN; i++) begin
          hist_q[i] <= '0;  // Empty window sums to zero
        end
      end else if (step_i) begin
        sum_q         <= sum_nxt;
        hist_q[idx_i] <= mix_in[ch];
      end
    end

    // Divide by 64 via bit select, then sign kept and rest inverted
    always_ff @(posedge adc_clk) begin
      if (step_i) begin
        dac_q[ch] <= {sum_nxt[`AVG_SUM_W-1], ~sum_nxt[`AVG_SUM_W-2:`AVG_IDX_W]};
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Output strobe
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_stb_o <= 1'b0;
    end else begin
      dac_stb_o <= step_i & out_en_i;  // Two cycles after input strobe
    end
  end

  assign dac_a_o = dac_q[0];
  assign dac_b_o = dac_q[1];

endmodule : moving_avg

//--- run_sim.sh
#!/bin/sh
# Compile and run the dac_path_top testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f dac_path_top.f --top-module tb_dac_path_top -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

//--- tb_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock, 4 ns period, and reset held for 10 cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 250 MHz
  end

  // Release just after an edge, like all other stimulus
  initial begin
    rstn_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #1 rstn_o = 1'b1;
  end

endmodule : tb_clk_gen

//--- tb_dac_path_top.sv
//////////////////////////////////////////////////////////////////////
// Table-driven testbench for dac_path_top with reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "dac_path_params.svh"

module tb_dac_path_top;

  import dac_path_pkg::*;

  typedef struct packed {
    logic [`ADC_RAW_W-1:0] raw_a;
    logic [`ADC_RAW_W-1:0] raw_b;
    sample_t               asg_a;
    sample_t               asg_b;
    sample_t               pid_a;
    sample_t               pid_b;
    logic                  loop;
    logic [3:0]            gap;   // Idle cycles after strobe
    logic [2:0]            test;
  } row_t;

  typedef struct packed {
    logic [`SMP_W-1:0] a;
    logic [`SMP_W-1:0] b;
    int                cyc;       // Cycle of the sampling edge
    logic [2:0]        test;
  } exp_t;

  logic                  adc_clk;
  logic                  adc_rstn;
  logic                  sample_stb;
  logic                  digital_loop;
  logic [`ADC_RAW_W-1:0] adc_raw_a;
  logic [`ADC_RAW_W-1:0] adc_raw_b;
  sample_t               asg_a, asg_b, pid_a, pid_b;
  sample_t               adc_a, adc_b;
  logic                  adc_stb;
  logic [`SMP_W-1:0]     dac_a, dac_b;
  logic                  dac_stb;

  row_t    tbl [256];
  int      n_rows    = 0;
  int      n_strobes = 0;
  int      cycle     = 0;
  int      limit     = 100000;  // Replaced once table is built
  int      cur_test  = 1;
  int      err [7];
  exp_t    adc_q [$];           // Pending ADC side results
  exp_t    dac_q [$];
  sample_t hist_a [$];          // Model window, oldest first
  sample_t hist_b [$];
  string   names [7] = '{"", "reset_quiet", "adc_convert", "saturation",
                         "moving_avg", "loopback", "strobe_gaps"};

  tb_clk_gen i_clk_gen (.clk_o(adc_clk), .rstn_o(adc_rstn));

  dac_path_top uut (
    .adc_clk        (adc_clk     ),
    .adc_rstn       (adc_rstn    ),
    .sample_stb_i   (sample_stb  ),
    .digital_loop_i (digital_loop),
    .adc_raw_a_i    (adc_raw_a   ),
    .adc_raw_b_i    (adc_raw_b   ),
    .asg_a_i        (asg_a       ),
    .asg_b_i        (asg_b       ),
    .pid_a_i        (pid_a       ),
    .pid_b_i        (pid_b       ),
    .adc_a_o        (adc_a       ),
    .adc_b_o        (adc_b       ),
    .adc_stb_o      (adc_stb     ),
    .dac_a_o        (dac_a       ),
    .dac_b_o        (dac_b       ),
    .dac_stb_o      (dac_stb     )
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Upper 14 bits, magnitude flipped
  function automatic sample_t adc_conv(input logic [`ADC_RAW_W-1:0] raw);
    adc_conv = sample_t'(raw[`ADC_RAW_W-1:2] ^ 14'h1FFF);
  endfunction

  function automatic sample_t sat_sum(input sample_t x, input sample_t y);
    int s;
    s = int'(x) + int'(y);
    if (s > 8191) begin
      s = 8191;
    end else if (s < -8192) begin
      s = -8192;
    end
    sat_sum = sample_t'(s);
  endfunction

  // Floor of sum/64, then offset code with slope reversed
  function automatic logic [`SMP_W-1:0] dac_code(input int sum);
    avg_sum_t s;
    s = avg_sum_t'(sum);
    dac_code = `SMP_W'(s >>> 6) ^ 14'h1FFF;
  endfunction

  task automatic add_row(input logic [15:0] ra, input logic [15:0] rb, input int aa,
                         input int ab, input int pa, input int pb, input logic lp,
                         input int gap, input int t);
    row_t r;
    r.raw_a = ra;
    r.raw_b = rb;
    r.asg_a = sample_t'(aa);
    r.asg_b = sample_t'(ab);
    r.pid_a = sample_t'(pa);
    r.pid_b = sample_t'(pb);
    r.loop  = lp;
    r.gap   = 4'(gap);
    r.test  = 3'(t);
    tbl[n_rows] = r;
    n_rows++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Driver, one strobe per row
  //////////////////////////////////////////////////////////////////////

  task automatic apply_row(input row_t r);
    exp_t    ea;
    exp_t    ed;
    sample_t ma;
    sample_t mb;
    int      sa;
    int      sb;
    adc_raw_a    = r.raw_a;
    adc_raw_b    = r.raw_b;
    asg_a        = r.asg_a;
    asg_b        = r.asg_b;
    pid_a        = r.pid_a;
    pid_b        = r.pid_b;
    digital_loop = r.loop;
    sample_stb   = 1'b1;
    ma = sat_sum(r.asg_a, r.pid_a);
    mb = sat_sum(r.asg_b, r.pid_b);
    n_strobes++;
    ea.cyc  = cycle + 1;  // Taken at next edge
    ea.test = r.test;
    ea.a    = r.loop ? ma : adc_conv(r.raw_a);
    ea.b    = r.loop ? mb : adc_conv(r.raw_b);
    adc_q.push_back(ea);
    hist_a.push_back(ma);
    hist_b.push_back(mb);
    if (hist_a.size() > `AVG_LEN) begin
      void'(hist_a.pop_front());
      void'(hist_b.pop_front());
    end
    if (n_strobes > `AVG_LEN) begin  // Output from strobe 65
      sa = 0;
      sb = 0;
      for (int i = 0; i < hist_a.size(); i++) begin
        sa += int'(hist_a[i]);
        sb += int'(hist_b[i]);
      end
      ed.a    = dac_code(sa);
      ed.b    = dac_code(sb);
      ed.cyc  = ea.cyc;
      ed.test = r.test;
      dac_q.push_back(ed);
    end
    @(posedge adc_clk);
    #1 sample_stb = 1'b0;
    repeat (r.gap) begin
      @(posedge adc_clk);
      #1;
    end
  endtask

  // Let pending results come out, then a few quiet cycles
  task automatic drain;
    while (adc_q.size() != 0 || dac_q.size() != 0) begin
      @(posedge adc_clk);
    end
    repeat (3) @(posedge adc_clk);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor, mid-cycle sampling
  //////////////////////////////////////////////////////////////////////

  task automatic compare_out(input string name, input exp_t e, input logic [13:0] a,
                             input logic [13:0] b, input int lag);
    if (cycle != e.cyc + lag) begin
      $display("%s strobe arrived in cycle %0d, expected in cycle %0d", name, cycle,
               e.cyc + lag);
      err[e.test]++;
    end
    if (a !== e.a || b !== e.b) begin
      $display("CHECK FAILED t=%0t %s a=%h exp %h, b=%h exp %h", $time, name, a, e.a,
               b, e.b);
      err[e.test]++;
    end
  endtask

  always @(negedge adc_clk) begin
    exp_t e;
    if (adc_stb) begin
      if (adc_q.size() == 0) begin
        $display("adc_stb_o went high at %0t with no sample strobe pending", $time);
        err[cur_test]++;
      end else begin
        e = adc_q.pop_front();
        compare_out("adc", e, adc_a, adc_b, 0);
      end
    end
    if (dac_stb) begin
      if (dac_q.size() == 0) begin
        $display("dac_stb_o went high at %0t before the window was full", $time);
        err[cur_test]++;
      end else begin
        e = dac_q.pop_front();
        compare_out("dac", e, dac_a, dac_b, 1);  // One cycle behind ADC side
      end
    end
  end

  // Run limit
  always @(posedge adc_clk) begin
    cycle <= cycle + 1;
    if (cycle > limit) begin
      $display("Timeout after %0d cycles, the DUT stopped producing results", limit);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Table and sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int sx [8];
    int sy [8];
    int max_gap;
    int total;
    int failed;
    void'($urandom(47270));
    sample_stb   = 1'b0;
    digital_loop = 1'b0;
    adc_raw_a    = '0;
    adc_raw_b    = '0;
    asg_a        = '0;
    asg_b        = '0;
    pid_a        = '0;
    pid_b        = '0;
    foreach (err[i]) err[i] = 0;
    // Full scale, zero, midscale, dropped LSBs
    add_row(16'h0000, 16'hFFFC, 11, -5, 7, 3, 1'b0, 1, 2);
    add_row(16'hFFFC, 16'h0000, -300, 40, 2, 9, 1'b0, 1, 2);
    add_row(16'h7FFC, 16'h8000, 1000, 0, -1000, 0, 1'b0, 1, 2);
    add_row(16'h8000, 16'h7FFC, 25, 2500, 25, -900, 1'b0, 1, 2);
    add_row(16'h4000, 16'hBFFF, -77, 64, 0, -64, 1'b0, 1, 2);
    for (int i = 0; i < 5; i++) begin
      add_row($urandom, $urandom, $urandom, $urandom, $urandom, $urandom, 1'b0, 1, 2);
    end
    // Rails, exact limits and in-range sums
    sx = '{8191, 8191, -8192, -8192, 4000, -4096, 5000, 8191};
    sy = '{1, 8191, -1, -8192, 4191, -4096, -3000, -8192};
    for (int i = 0; i < 8; i++) begin
      add_row($urandom, $urandom, sx[i], sy[7-i], sy[i], sx[7-i], 1'b1, 0, 3);
    end
    for (int i = 0; i < 2; i++) begin
      add_row($urandom, $urandom, $urandom, $urandom, $urandom, $urandom, 1'b1, 0, 3);
    end
    // Constant level, then a step
    for (int i = 0; i < 64; i++) begin
      add_row($urandom, $urandom, 1000, -2000, 234, -48, 1'b0, 0, 4);
    end
    for (int i = 0; i < 70; i++) begin
      add_row($urandom, $urandom, -3000, 3000, -1000, 4000, 1'b0, 0, 4);
    end
    for (int i = 0; i < 8; i++) begin
      add_row($urandom, $urandom, $urandom, $urandom, $urandom, $urandom, 1'b1, 2, 5);
    end
    for (int i = 0; i < 30; i++) begin
      add_row($urandom, $urandom, $urandom, $urandom, $urandom, $urandom, 1'b0,
              int'($urandom_range(0, 7)), 6);
    end
    max_gap = 0;
    for (int i = 0; i < n_rows; i++) begin
      if (int'(tbl[i].gap) > max_gap) max_gap = int'(tbl[i].gap);
    end
    limit = n_rows * (1 + max_gap) + 200;

    @(posedge adc_rstn);
    @(posedge adc_clk);
    #1;
    repeat (20) @(posedge adc_clk);  // Quiet after reset
    #1;
    $display("Test 1 %s: %0d errors", names[1], err[1]);
    for (int t = 2; t <= 6; t++) begin
      cur_test = t;
      for (int i = 0; i < n_rows; i++) begin
        if (int'(tbl[i].test) == t) apply_row(tbl[i]);
      end
      drain();
      $display("Test %0d %s: %0d errors", t, names[t], err[t]);
    end

    total  = 0;
    failed = 0;
    for (int t = 1; t <= 6; t++) begin
      total += err[t];
      if (err[t] != 0) failed++;
    end
    $display("Tests: 6 run, %0d failed, %0d errors, %0d strobes", failed, total, n_strobes);
    if (total == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tb_dac_path_top
